// ==== run.sh ====
#!/usr/bin/env bash
# Build the adder testbench with Verilator, run it and look for the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module fpAdderTb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/VfpAdderTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" <<< "$output"; then
    exit 0
fi
exit 1

// ==== src.f ====
src/fpPkg.sv
src/fpBus.sv
src/fpAlign.sv
src/fpAddSub.sv
src/fpNormalize.sv
src/fpAdder.sv
verification/fpClockGen.sv
verification/fpAdderTb.sv

// ==== src/fpAddSub.sv ====
// Stage 2: effective operation and extended significand add or subtract.
`timescale 1ns/1ps
`default_nettype none

module fpAddSub (
    input  wire logic clk,
    input  wire logic arstN,
    fpBus.adder       bus
);
    import fpPkg::*;

    logic                effSubtract;
    logic [sumWidth-1:0] mantA;
    logic [sumWidth-1:0] mantB;
    logic [sumWidth-1:0] magnitude;

    always_comb
    begin
        // Signs differ once B carries the requested operation.
        effSubtract = bus.alignSignA ^ (bus.alignSignB ^ bus.alignSubtract);

        mantA = {1'b0, bus.alignMantA};
        mantB = {1'b0, bus.alignMantB};

        // A holds the larger magnitude, so the difference stays positive.
        if (effSubtract)
        begin
            magnitude = mantA - mantB;
        end
        else
        begin
            magnitude = mantA + mantB;                  // Carry lands in the top bit.
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            bus.sumValid     <= 1'b0;
            bus.sumSign      <= 1'b0;
            bus.sumExponent  <= '0;
            bus.sumMagnitude <= '0;
        end
        else
        begin
            bus.sumValid     <= bus.alignValid;
            bus.sumSign      <= bus.alignSignA;
            bus.sumExponent  <= bus.alignExponent;
            bus.sumMagnitude <= magnitude;
        end
    end

endmodule

`default_nettype wire

// ==== src/fpAdder.sv ====
// Top level of the three-stage single-precision adder/subtractor.
`timescale 1ns/1ps
`default_nettype none

module fpAdder (
    input  wire logic                                    clk,
    input  wire logic                                    arstN,
    input  wire logic                                    inValid,
    input  wire logic [fpPkg::expWidth+fpPkg::manWidth:0] opA,
    input  wire logic [fpPkg::expWidth+fpPkg::manWidth:0] opB,
    input  wire logic                                    subtract,
    output logic                                         outValid,
    output logic [fpPkg::expWidth+fpPkg::manWidth:0]     result
);

    fpBus stageBus ();                                  // Both stage boundaries.

    fpAlign fpAlign_i (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .opA      (opA),
        .opB      (opB),
        .subtract (subtract),
        .bus      (stageBus.align)
    );

    fpAddSub fpAddSub_i (
        .clk   (clk),
        .arstN (arstN),
        .bus   (stageBus.adder)
    );

    fpNormalize fpNormalize_i (
        .clk      (clk),
        .arstN    (arstN),
        .bus      (stageBus.normal),
        .outValid (outValid),
        .result   (result)
    );

endmodule

`default_nettype wire

// ==== src/fpAlign.sv ====
// Stage 1: unpack, order by magnitude, align the smaller operand with sticky.
`timescale 1ns/1ps
`default_nettype none

module fpAlign (
    input  wire logic                                   clk,
    input  wire logic                                   arstN,
    input  wire logic                                   inValid,
    input  wire logic [fpPkg::expWidth+fpPkg::manWidth:0] opA,
    input  wire logic [fpPkg::expWidth+fpPkg::manWidth:0] opB,
    input  wire logic                                   subtract,
    fpBus.align                                         bus
);
    import fpPkg::*;

    localparam int magTop = expWidth + manWidth - 1;   // Top bit below the sign.

    logic                         swap;
    logic                         flipSign;
    logic [expWidth+manWidth:0]   largeOp;
    logic [expWidth+manWidth:0]   smallOp;
    logic [sigWidth-1:0]          largeSig;
    logic [sigWidth-1:0]          smallSig;
    logic [expWidth-1:0]          expDiff;
    logic [4:0]                   shiftAmt;
    logic [2*extWidth-1:0]        shiftedWide;

    always_comb
    begin
        swap    = opB[magTop:0] > opA[magTop:0];        // Exponent then fraction.
        largeOp = swap ? opB : opA;
        smallOp = swap ? opA : opB;

        // Zero exponent field means zero.
        largeSig = (largeOp[magTop:manWidth] != '0) ? {1'b1, largeOp[manWidth-1:0]} : '0;
        smallSig = (smallOp[magTop:manWidth] != '0) ? {1'b1, smallOp[manWidth-1:0]} : '0;

        expDiff  = largeOp[magTop:manWidth] - smallOp[magTop:manWidth];
        shiftAmt = (expDiff > expWidth'(extWidth)) ? 5'(extWidth) : expDiff[4:0];

        // Lower half collects every bit shifted past the round position.
        shiftedWide = {smallSig, {(2*extWidth-sigWidth){1'b0}}} >> shiftAmt;

        // A swapped subtraction is -(B - A), so the flip moves to A.
        flipSign = swap & subtract;
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            bus.alignValid    <= 1'b0;
            bus.alignSignA    <= 1'b0;
            bus.alignSignB    <= 1'b0;
            bus.alignSubtract <= 1'b0;
            bus.alignExponent <= '0;
            bus.alignMantA    <= '0;
            bus.alignMantB    <= '0;
        end
        else
        begin
            bus.alignValid    <= inValid;
            bus.alignSignA    <= largeOp[expWidth+manWidth] ^ flipSign;
            bus.alignSignB    <= smallOp[expWidth+manWidth] ^ flipSign;
            bus.alignSubtract <= subtract;
            bus.alignExponent <= largeOp[magTop:manWidth];
            bus.alignMantA    <= {largeSig, {(extWidth-sigWidth){1'b0}}};
            bus.alignMantB    <= {shiftedWide[2*extWidth-1:extWidth+1],
                                  shiftedWide[extWidth] | (|shiftedWide[extWidth-1:0])};
        end
    end

endmodule

`default_nettype wire

// ==== src/fpBus.sv ====
// Interface for the align and sum stage boundaries, with one modport per stage.
`timescale 1ns/1ps
`default_nettype none

interface fpBus;
    import fpPkg::*;

    // Aligned operands, larger magnitude in A.
    logic                alignValid;
    logic                alignSignA;
    logic                alignSignB;
    logic                alignSubtract;
    logic [expWidth-1:0] alignExponent;
    logic [extWidth-1:0] alignMantA;
    logic [extWidth-1:0] alignMantB;

    // Raw sum before renormalisation.
    logic                sumValid;
    logic                sumSign;
    logic [expWidth-1:0] sumExponent;
    logic [sumWidth-1:0] sumMagnitude;

    modport align (
        output alignValid, alignSignA, alignSignB, alignSubtract,
        output alignExponent, alignMantA, alignMantB
    );

    modport adder (
        input  alignValid, alignSignA, alignSignB, alignSubtract,
        input  alignExponent, alignMantA, alignMantB,
        output sumValid, sumSign, sumExponent, sumMagnitude
    );

    modport normal (
        input sumValid, sumSign, sumExponent, sumMagnitude
    );

endinterface

`default_nettype wire

// ==== src/fpNormalize.sv ====
// Stage 3: renormalise, round to nearest even and repack the result.
`timescale 1ns/1ps
`default_nettype none

module fpNormalize (
    input  wire logic                                    clk,
    input  wire logic                                    arstN,
    fpBus.normal                                         bus,
    output logic                                         outValid,
    output logic [fpPkg::expWidth+fpPkg::manWidth:0]     result
);
    import fpPkg::*;

    localparam int lsbPos = sumWidth - sigWidth;        // Lowest kept fraction bit.

    logic [4:0]             shiftAmount;
    logic [sumWidth-1:0]    shiftedMantissa;
    logic [expWidth-1:0]    shiftedExponent;
    logic                   guardBit;
    logic                   roundBit;
    logic                   stickyBit;
    logic                   roundUp;
    logic [sigWidth:0]      roundedMantissa;
    logic [expWidth-1:0]    finalExponent;
    logic [expWidth+manWidth:0] packedResult;

    always_comb
    begin
        // Hidden one ends up in the carry position; a carry needs no shift.
        shiftAmount     = countLeadingZeros(bus.sumMagnitude);
        shiftedMantissa = bus.sumMagnitude << shiftAmount;
        shiftedExponent = bus.sumExponent + expWidth'(1) - expWidth'(shiftAmount);

        guardBit  = shiftedMantissa[lsbPos-1];
        roundBit  = shiftedMantissa[lsbPos-2];
        stickyBit = |shiftedMantissa[lsbPos-3:0];       // Carry case folds bit 0 in here.

        // Ties go to an even lowest bit.
        roundUp = guardBit & (roundBit | stickyBit | shiftedMantissa[lsbPos]);

        roundedMantissa = {1'b0, shiftedMantissa[sumWidth-1:lsbPos]} + (sigWidth+1)'(roundUp);

        // Overflowing the significand leaves a zero fraction.
        finalExponent = shiftedExponent + expWidth'(roundedMantissa[sigWidth]);

        if (bus.sumMagnitude == '0)
        begin
            packedResult = '0;                          // Exact zero is +0.
        end
        else
        begin
            packedResult = {bus.sumSign, finalExponent, roundedMantissa[manWidth-1:0]};
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            outValid <= 1'b0;
            result   <= '0;
        end
        else
        begin
            outValid <= bus.sumValid;
            result   <= packedResult;
        end
    end

endmodule

`default_nettype wire

// ==== src/fpPkg.sv ====
// Single-precision format widths, exponent bias and leading-zero counter.
`default_nettype none

package fpPkg;

    localparam int expWidth = 8;                   // Exponent field.
    localparam int manWidth = 23;                  // Stored fraction.
    localparam int sigWidth = manWidth + 1;        // Fraction plus hidden one.
    localparam int extWidth = sigWidth + 3;        // Guard, round and sticky appended.
    localparam int sumWidth = extWidth + 1;        // One carry bit on top.
    localparam int expBias = 127;

    // Leading zeros of the adder output; an all-zero vector gives sumWidth.
    function automatic logic [4:0] countLeadingZeros(input logic [sumWidth-1:0] value);
        logic [4:0] count;
        logic found;
        count = 5'(sumWidth);
        found = 1'b0;
        for (int i = sumWidth - 1; i >= 0; i--)
        begin
            if (!found && value[i])
            begin
                count = 5'(sumWidth - 1 - i);
                found = 1'b1;
            end
        end
        return count;
    endfunction

endpackage

`default_nettype wire

// ==== verification/fpAdderTb.sv ====
// Testbench for the pipelined adder: random operands, reference model, checker and watchdog.
`timescale 1ns/1ps
`default_nettype none

module fpAdderTb;

    localparam int itemCount = 600;
    localparam int maxGap    = 3;                       // Most idle cycles between items.
    localparam int latency   = 3;
    localparam int timeoutNs = (itemCount * (maxGap + 1) + 100) * 8;

    logic        clk;
    logic        arstN;
    logic        inValid;
    logic [31:0] opA;
    logic [31:0] opB;
    logic        subtract;
    logic        outValid;
    logic [31:0] result;

    integer      seed = 32'h086e_a1e8;
    int          cycleCount = 0;
    int          checkedCount = 0;
    int          valueErrors = 0;
    int          otherErrors = 0;
    logic [31:0] expectedQ[$];
    int          dueQ[$];

    fpClockGen clockGen_i (
        .clk   (clk),
        .arstN (arstN)
    );

    fpAdder fpAdder_i (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .opA      (opA),
        .opB      (opB),
        .subtract (subtract),
        .outValid (outValid),
        .result   (result)
    );

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
    end

    function automatic int pickBelow(input int span);
        return int'($unsigned($random(seed)) % span);
    endfunction

    // Exact widening of a single to a double.
    function automatic real toReal(input logic [31:0] value);
        logic [63:0] bits;
        if (value[30:23] == 8'd0)
        begin
            return 0.0;
        end
        bits = {value[31], 11'(value[30:23]) + 11'd896, value[22:0], 29'd0};
        return $bitstoreal(bits);
    endfunction

    function automatic logic [31:0] roundToSingle(input real value);
        logic [63:0] bits;
        logic [24:0] kept;
        logic [28:0] rest;
        logic [7:0]  exponent;
        bits = $realtobits(value);
        if (value == 0.0)
        begin
            return 32'd0;                               // Either zero sign gives +0.
        end
        exponent = 8'(bits[62:52] - 11'd896);
        kept     = {2'b01, bits[51:29]};
        rest     = bits[28:0];
        if (rest > 29'h1000_0000 || (rest == 29'h1000_0000 && kept[0]))
        begin
            kept = kept + 25'd1;
        end
        if (kept[24])
        begin
            exponent = exponent + 8'd1;                 // Fraction is zero after the carry.
        end
        return {bits[63], exponent, kept[22:0]};
    endfunction

    function automatic logic [31:0] referenceResult(input logic [31:0] a, input logic [31:0] b,
                                                    input logic sub);
        logic bLarger;
        int   diff;
        bLarger = b[30:0] > a[30:0];
        diff    = bLarger ? int'(b[30:23]) - int'(a[30:23]) : int'(a[30:23]) - int'(b[30:23]);
        if (diff >= 26)
        begin
            return bLarger ? {b[31] ^ sub, b[30:0]} : a;
        end
        return roundToSingle(sub ? toReal(a) - toReal(b) : toReal(a) + toReal(b));
    endfunction

    task automatic makePair(output logic [31:0] a, output logic [31:0] b, output logic sub);
        int          mode;
        int          expA;
        int          diff;
        int          mask;
        logic        signA;
        logic        signB;
        logic [22:0] fracA;
        logic [22:0] fracB;
        logic [31:0] spare;
        mode  = pickBelow(6);
        expA  = 30 + pickBelow(190);
        diff  = pickBelow(30);
        fracA = 23'($random(seed));
        fracB = 23'($random(seed));
        signA = 1'(pickBelow(2));
        signB = 1'(pickBelow(2));
        sub   = 1'(pickBelow(2));
        case (mode)
            1:
            begin
                diff  = pickBelow(3);                   // Same sign so a carry is likely.
                signB = signA;
                sub   = 1'b0;
            end
            2:
            begin
                diff  = pickBelow(2);                   // Near-equal operands to subtract.
                fracB = fracA ^ 23'(pickBelow(16));
                signB = signA;
                sub   = 1'b1;
            end
            3:
            begin
                diff  = 1 + pickBelow(4);               // Guard set with sticky clear or set.
                mask  = (1 << diff) - 1;
                fracB = (fracB & ~23'(mask)) | 23'(1 << (diff - 1));
                if (pickBelow(2) == 1)
                begin
                    fracB = fracB | 23'(pickBelow(1 << (diff - 1)));
                end
            end
            4:
            begin
                expA = 70 + pickBelow(150);
                diff = 26 + pickBelow(15);
            end
            default:
            begin
            end
        endcase
        a = {signA, 8'(expA), fracA};
        b = {signB, 8'(expA - diff), fracB};
        if (mode == 5)
        begin
            b = {signB, 31'd0};
            if (pickBelow(4) == 0)
            begin
                a = {signA, 31'd0};
            end
        end
        if (pickBelow(2) == 1)
        begin
            spare = a;
            a     = b;
            b     = spare;
        end
    endtask

    task automatic checkOutputs();
        if (expectedQ.size() == 0)
        begin
            if (outValid !== 1'b0)
            begin
                $display("At %0t outValid is high with no item in flight", $time);
                otherErrors++;
            end
        end
        else if (outValid === 1'b1 || dueQ[0] == cycleCount)
        begin
            if (dueQ[0] != cycleCount)
            begin
                $display("At %0t a result came at cycle %0d, due at cycle %0d",
                         $time, cycleCount, dueQ[0]);
                otherErrors++;
            end
            else if (outValid !== 1'b1)
            begin
                $display("At %0t the result due at cycle %0d did not come", $time, dueQ[0]);
                otherErrors++;
            end
            if (outValid === 1'b1)
            begin
                checkedCount++;
                if (result !== expectedQ[0])
                begin
                    $display("[ERROR] %0t result: got %h, expected %h",
                             $time, result, expectedQ[0]);
                    valueErrors++;
                end
            end
            void'(expectedQ.pop_front());
            void'(dueQ.pop_front());
        end
    endtask

    initial
    begin
        logic [31:0] a;
        logic [31:0] b;
        logic        sub;
        int          gap;
        inValid  = 1'b0;
        opA      = '0;
        opB      = '0;
        subtract = 1'b0;
        while (arstN !== 1'b1)
        begin
            @(negedge clk);
            if (outValid !== 1'b0)
            begin
                $display("At %0t outValid is not low during reset", $time);
                otherErrors++;
            end
        end
        for (int n = 0; n < itemCount; n++)
        begin
            gap = (pickBelow(3) == 0) ? 1 + pickBelow(maxGap) : 0;
            repeat (gap)
            begin
                @(negedge clk);
                checkOutputs();
                inValid = 1'b0;
            end
            @(negedge clk);
            checkOutputs();
            makePair(a, b, sub);
            opA      = a;
            opB      = b;
            subtract = sub;
            inValid  = 1'b1;
            expectedQ.push_back(referenceResult(a, b, sub));
            dueQ.push_back(cycleCount + latency);
        end
        @(negedge clk);
        checkOutputs();
        inValid = 1'b0;
        while (expectedQ.size() != 0)
        begin
            @(negedge clk);
            checkOutputs();
        end
        repeat (4)
        begin
            @(negedge clk);
            checkOutputs();                             // No stray strobes after the drain.
        end
        if (checkedCount != itemCount)
        begin
            $display("Only %0d of %0d results were checked", checkedCount, itemCount);
            otherErrors++;
        end
        $display("Checked %0d results: %0d value errors, %0d other errors",
                 checkedCount, valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

    initial
    begin
        #(timeoutNs);
        $display("Watchdog expired after %0d ns with %0d results outstanding",
                 timeoutNs, expectedQ.size());
        $display("Checked %0d results: %0d value errors, %0d other errors",
                 checkedCount, valueErrors, otherErrors);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/fpClockGen.sv ====
// Testbench clock and active-low reset generator.
`timescale 1ns/1ps
`default_nettype none

module fpClockGen #(
    parameter int periodNs    = 8,
    parameter int resetCycles = 2
) (
    output logic clk,
    output logic arstN
);

    initial
    begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    initial
    begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;                                   // Released away from the sampling edge.
    end

endmodule

`default_nettype wire
